// File: common/rd_cdc_pkg.sv
package rd_cdc_pkg;

    ////////////////////
    // sizes

    // one lane per read ID
    localparam int NUM_LANES = 4;
    localparam int ID_W = $clog2(NUM_LANES);

    // entries per lane, kept even for the johnson code
    localparam int LANE_DEPTH = 8;

    localparam int DATA_W = 32;

    // address bits plus one wrap bit
    localparam int PTR_W = $clog2(LANE_DEPTH) + 1;

    // flops on each pointer crossing
    localparam int SYNC_STAGES = 2;

    ////////////////////
    // types

    typedef logic [DATA_W-1:0] data_t;

    typedef logic [ID_W-1:0] id_t;

    // one bit per lane
    typedef logic [NUM_LANES-1:0] lane_mask_t;

    typedef logic [PTR_W-1:0] ptr_t;

    // one bit per entry, a full johnson cycle is 2*LANE_DEPTH steps
    typedef logic [LANE_DEPTH-1:0] jptr_t;

endpackage : rd_cdc_pkg

// File: fifo/johnson_ptr.sv
`timescale 1ns/1ps

module johnson_ptr (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_enable,
    output rd_cdc_pkg::ptr_t  o_ptr_bin,
    output rd_cdc_pkg::ptr_t  o_ptr_bin_next,
    output rd_cdc_pkg::jptr_t o_ptr_john
);
    import rd_cdc_pkg::*;

    ptr_t bin_inc;

    ////////////////////
    // binary count

    // wraps after twice the depth, top bit flips once per pass
    always_comb begin
        if (o_ptr_bin == ptr_t'(2 * LANE_DEPTH - 1)) begin
            bin_inc = '0;
        end else begin
            bin_inc = ptr_t'(o_ptr_bin + 1'b1);
        end
    end

    // used by full and empty before the register updates
    assign o_ptr_bin_next = i_enable ? bin_inc : o_ptr_bin;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ptr_bin <= '0;
        end else begin
            o_ptr_bin <= o_ptr_bin_next;
        end
    end

    ////////////////////
    // johnson count

    // shift in the inverted top bit, one bit changes per step
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ptr_john <= '0;
        end else if (i_enable) begin
            o_ptr_john <= {o_ptr_john[LANE_DEPTH-2:0], ~o_ptr_john[LANE_DEPTH-1]};
        end
    end

endmodule : johnson_ptr

// File: fifo/ptr_cross.sv
`timescale 1ns/1ps

module ptr_cross (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  rd_cdc_pkg::jptr_t i_ptr_john,
    output rd_cdc_pkg::ptr_t  o_ptr_bin
);
    import rd_cdc_pkg::*;

    jptr_t          sync_q [SYNC_STAGES];
    jptr_t          john_sync;
    logic [PTR_W:0] ones_cnt;

    ////////////////////
    // synchronizer

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= i_ptr_john;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign john_sync = sync_q[SYNC_STAGES-1];

    ////////////////////
    // johnson to binary

    always_comb begin
        ones_cnt = '0;
        for (int i = 0; i < LANE_DEPTH; i++) begin
            if (john_sync[i]) begin
                ones_cnt = ones_cnt + 1'b1;
            end
        end
    end

    // top bit set means the draining half, count back from 2*depth
    always_comb begin
        if (john_sync[LANE_DEPTH-1]) begin
            o_ptr_bin = ptr_t'(2 * LANE_DEPTH - int'(ones_cnt));
        end else begin
            o_ptr_bin = ptr_t'(ones_cnt);
        end
    end

endmodule : ptr_cross

// File: fifo/fifo_async_lane.sv
`timescale 1ns/1ps

module fifo_async_lane (
    input  logic              i_axi_wr_aclk,
    input  logic              i_axi_wr_aresetn,
    input  logic              i_axi_rd_aclk,
    input  logic              i_axi_rd_aresetn,
    input  logic              i_wr_valid,
    input  rd_cdc_pkg::data_t i_wr_data,
    output logic              o_wr_ready,
    input  logic              i_rd_ready,
    output logic              o_rd_valid,
    output rd_cdc_pkg::data_t o_rd_data
);
    import rd_cdc_pkg::*;

    // flop storage
    data_t mem [LANE_DEPTH];

    // write side
    ptr_t  wr_ptr_bin;
    ptr_t  wr_ptr_bin_next;
    jptr_t wr_ptr_john;
    ptr_t  wdom_rd_ptr_bin;
    logic  wr_full;
    logic  wr_push;

    // read side
    ptr_t  rd_ptr_bin;
    ptr_t  rd_ptr_bin_next;
    jptr_t rd_ptr_john;
    ptr_t  rdom_wr_ptr_bin;
    logic  rd_empty;
    logic  rd_pop;

    assign wr_push = i_wr_valid && !wr_full;
    assign rd_pop  = i_rd_ready && !rd_empty;

    ////////////////////
    // pointers

    johnson_ptr u_wr_ptr (
        .i_clk          (i_axi_wr_aclk),
        .i_rst_n        (i_axi_wr_aresetn),
        .i_enable       (wr_push),
        .o_ptr_bin      (wr_ptr_bin),
        .o_ptr_bin_next (wr_ptr_bin_next),
        .o_ptr_john     (wr_ptr_john)
    );

    johnson_ptr u_rd_ptr (
        .i_clk          (i_axi_rd_aclk),
        .i_rst_n        (i_axi_rd_aresetn),
        .i_enable       (rd_pop),
        .o_ptr_bin      (rd_ptr_bin),
        .o_ptr_bin_next (rd_ptr_bin_next),
        .o_ptr_john     (rd_ptr_john)
    );

    ////////////////////
    // crossings

    // read pointer into the write clock
    ptr_cross u_rd_to_wr (
        .i_clk      (i_axi_wr_aclk),
        .i_rst_n    (i_axi_wr_aresetn),
        .i_ptr_john (rd_ptr_john),
        .o_ptr_bin  (wdom_rd_ptr_bin)
    );

    // write pointer into the read clock
    ptr_cross u_wr_to_rd (
        .i_clk      (i_axi_rd_aclk),
        .i_rst_n    (i_axi_rd_aresetn),
        .i_ptr_john (wr_ptr_john),
        .o_ptr_bin  (rdom_wr_ptr_bin)
    );

    ////////////////////
    // storage

    always_ff @(posedge i_axi_wr_aclk) begin
        if (wr_push) begin
            mem[wr_ptr_bin[PTR_W-2:0]] <= i_wr_data;
        end
    end

    // head of the lane, valid whenever not empty
    assign o_rd_data = mem[rd_ptr_bin[PTR_W-2:0]];

    ////////////////////
    // full and empty

    // full when the wrap bits differ and the addresses match
    always_ff @(posedge i_axi_wr_aclk or negedge i_axi_wr_aresetn) begin
        if (!i_axi_wr_aresetn) begin
            wr_full <= 1'b0;
        end else begin
            wr_full <= (wr_ptr_bin_next ==
                        {~wdom_rd_ptr_bin[PTR_W-1], wdom_rd_ptr_bin[PTR_W-2:0]});
        end
    end

    // empty when the pointers are equal
    always_ff @(posedge i_axi_rd_aclk or negedge i_axi_rd_aresetn) begin
        if (!i_axi_rd_aresetn) begin
            rd_empty <= 1'b1;
        end else begin
            rd_empty <= (rd_ptr_bin_next == rdom_wr_ptr_bin);
        end
    end

    assign o_wr_ready = !wr_full;
    assign o_rd_valid = !rd_empty;

endmodule : fifo_async_lane

// File: source/beat_steer.sv
`timescale 1ns/1ps

module beat_steer (
    input  logic                   i_wr_valid,
    input  rd_cdc_pkg::id_t        i_wr_id,
    input  rd_cdc_pkg::lane_mask_t i_lane_ready,
    output logic                   o_wr_ready,
    output rd_cdc_pkg::lane_mask_t o_lane_valid
);
    import rd_cdc_pkg::*;

    ////////////////////
    // valid to the addressed lane

    // one-hot decode of the ID, nothing when idle
    always_comb begin
        o_lane_valid = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (i_wr_valid && (i_wr_id == id_t'(i))) begin
                o_lane_valid[i] = 1'b1;
            end
        end
    end

    ////////////////////
    // ready back upstream

    // only the addressed lane can stall the source,
    // so a full lane does not block other IDs
    assign o_wr_ready = i_lane_ready[i_wr_id];

endmodule : beat_steer

// File: source/lane_drain_rr.sv
`timescale 1ns/1ps

module lane_drain_rr (
    input  logic                   i_axi_rd_aclk,
    input  logic                   i_axi_rd_aresetn,
    input  rd_cdc_pkg::lane_mask_t i_lane_valid,
    input  rd_cdc_pkg::data_t      i_lane_data [rd_cdc_pkg::NUM_LANES],
    output rd_cdc_pkg::lane_mask_t o_lane_pop,
    output logic                   o_rd_valid,
    output rd_cdc_pkg::id_t        o_rd_id,
    output rd_cdc_pkg::data_t      o_rd_data,
    input  logic                   i_rd_ready
);
    import rd_cdc_pkg::*;

    id_t  rr_ptr;
    id_t  grant_id;
    logic grant_valid;
    logic load_en;

    // output register empty or taken this cycle
    assign load_en = !o_rd_valid || i_rd_ready;

    ////////////////////
    // round-robin pick

    // first valid lane at or after the pointer, index wraps with id_t
    always_comb begin
        id_t scan_id;
        grant_valid = 1'b0;
        grant_id    = rr_ptr;
        for (int i = 0; i < NUM_LANES; i++) begin
            scan_id = id_t'(rr_ptr + id_t'(i));
            if (!grant_valid && i_lane_valid[scan_id]) begin
                grant_valid = 1'b1;
                grant_id    = scan_id;
            end
        end
    end

    always_comb begin
        o_lane_pop = '0;
        if (load_en && grant_valid) begin
            o_lane_pop[grant_id] = 1'b1;
        end
    end

    ////////////////////
    // output register

    always_ff @(posedge i_axi_rd_aclk or negedge i_axi_rd_aresetn) begin
        if (!i_axi_rd_aresetn) begin
            o_rd_valid <= 1'b0;
            rr_ptr     <= '0;
        end else if (load_en) begin
            o_rd_valid <= grant_valid;
            // next search starts past the granted lane
            if (grant_valid) begin
                rr_ptr <= id_t'(grant_id + 1'b1);
            end
        end
    end

    // the lane index doubles as the beat ID
    always_ff @(posedge i_axi_rd_aclk) begin
        if (load_en && grant_valid) begin
            o_rd_id   <= grant_id;
            o_rd_data <= i_lane_data[grant_id];
        end
    end

endmodule : lane_drain_rr

// File: source/rd_data_cdc_top.sv
`timescale 1ns/1ps

module rd_data_cdc_top (
    input  logic              i_axi_wr_aclk,
    input  logic              i_axi_wr_aresetn,
    input  logic              i_axi_rd_aclk,
    input  logic              i_axi_rd_aresetn,
    input  logic              i_wr_valid,
    input  rd_cdc_pkg::id_t   i_wr_id,
    input  rd_cdc_pkg::data_t i_wr_data,
    output logic              o_wr_ready,
    output logic              o_rd_valid,
    output rd_cdc_pkg::id_t   o_rd_id,
    output rd_cdc_pkg::data_t o_rd_data,
    input  logic              i_rd_ready
);
    import rd_cdc_pkg::*;

    lane_mask_t lane_wr_valid;
    lane_mask_t lane_wr_ready;
    lane_mask_t lane_rd_valid;
    lane_mask_t lane_pop;
    data_t      lane_rd_data [NUM_LANES];

    ////////////////////
    // write domain steer

    beat_steer u_steer (
        .i_wr_valid   (i_wr_valid),
        .i_wr_id      (i_wr_id),
        .i_lane_ready (lane_wr_ready),
        .o_wr_ready   (o_wr_ready),
        .o_lane_valid (lane_wr_valid)
    );

    ////////////////////
    // one lane per ID

    for (genvar g = 0; g < NUM_LANES; g++) begin : gen_lane
        fifo_async_lane u_lane (
            .i_axi_wr_aclk    (i_axi_wr_aclk),
            .i_axi_wr_aresetn (i_axi_wr_aresetn),
            .i_axi_rd_aclk    (i_axi_rd_aclk),
            .i_axi_rd_aresetn (i_axi_rd_aresetn),
            .i_wr_valid       (lane_wr_valid[g]),
            .i_wr_data        (i_wr_data),
            .o_wr_ready       (lane_wr_ready[g]),
            .i_rd_ready       (lane_pop[g]),
            .o_rd_valid       (lane_rd_valid[g]),
            .o_rd_data        (lane_rd_data[g])
        );
    end

    ////////////////////
    // read domain drain

    lane_drain_rr u_drain (
        .i_axi_rd_aclk    (i_axi_rd_aclk),
        .i_axi_rd_aresetn (i_axi_rd_aresetn),
        .i_lane_valid     (lane_rd_valid),
        .i_lane_data      (lane_rd_data),
        .o_lane_pop       (lane_pop),
        .o_rd_valid       (o_rd_valid),
        .o_rd_id          (o_rd_id),
        .o_rd_data        (o_rd_data),
        .i_rd_ready       (i_rd_ready)
    );

endmodule : rd_data_cdc_top

// File: test/rd_data_cdc_chk.sv
`timescale 1ns/1ps

module rd_data_cdc_chk (
    input logic              i_axi_wr_aclk,
    input logic              i_axi_wr_aresetn,
    input logic              i_axi_rd_aclk,
    input logic              i_axi_rd_aresetn,
    input logic              i_wr_ready,
    input logic              i_rd_valid,
    input logic              i_rd_pop,
    input rd_cdc_pkg::data_t i_rd_data,
    input rd_cdc_pkg::ptr_t  i_wr_ptr_bin,
    input rd_cdc_pkg::ptr_t  i_wdom_rd_ptr_bin
);
    import rd_cdc_pkg::*;

    // read by the testbench at the end of the run
    int unsigned fail_cnt = 0;

    ////////////////////
    // pointer moves

    // a write taken while full would push the lane past its depth
    wr_blocked_when_full : assert property (
        @(posedge i_axi_wr_aclk) disable iff (!i_axi_wr_aresetn)
        ptr_t'(i_wr_ptr_bin - i_wdom_rd_ptr_bin) <= ptr_t'(LANE_DEPTH)
    ) else begin
        $error("lane accepted a write while o_wr_ready was low");
        fail_cnt++;
    end

    // the drain strobes only a lane that shows a beat
    rd_blocked_when_empty : assert property (
        @(posedge i_axi_rd_aclk) disable iff (!i_axi_rd_aresetn)
        i_rd_pop |-> i_rd_valid
    ) else begin
        $error("lane popped while o_rd_valid was low");
        fail_cnt++;
    end

    ////////////////////
    // known outputs

    wr_ready_known : assert property (
        @(posedge i_axi_wr_aclk) disable iff (!i_axi_wr_aresetn)
        !$isunknown(i_wr_ready)
    ) else begin
        $error("lane o_wr_ready is unknown after reset");
        fail_cnt++;
    end

    rd_valid_known : assert property (
        @(posedge i_axi_rd_aclk) disable iff (!i_axi_rd_aresetn)
        !$isunknown(i_rd_valid)
    ) else begin
        $error("lane o_rd_valid is unknown after reset");
        fail_cnt++;
    end

    // head data only matters while the lane holds a beat
    rd_data_known : assert property (
        @(posedge i_axi_rd_aclk) disable iff (!i_axi_rd_aresetn)
        i_rd_valid |-> !$isunknown(i_rd_data)
    ) else begin
        $error("lane o_rd_data is unknown while o_rd_valid is high");
        fail_cnt++;
    end

endmodule : rd_data_cdc_chk

bind fifo_async_lane rd_data_cdc_chk u_chk (
    .i_axi_wr_aclk     (i_axi_wr_aclk),
    .i_axi_wr_aresetn  (i_axi_wr_aresetn),
    .i_axi_rd_aclk     (i_axi_rd_aclk),
    .i_axi_rd_aresetn  (i_axi_rd_aresetn),
    .i_wr_ready        (o_wr_ready),
    .i_rd_valid        (o_rd_valid),
    .i_rd_pop          (i_rd_ready),
    .i_rd_data         (o_rd_data),
    .i_wr_ptr_bin      (wr_ptr_bin),
    .i_wdom_rd_ptr_bin (wdom_rd_ptr_bin)
);

// File: test/tb_rd_data_cdc.sv
`timescale 1ns/1ps

module tb_rd_data_cdc;
    import rd_cdc_pkg::*;

    logic   i_axi_wr_aclk;
    logic   i_axi_wr_aresetn;
    logic   i_axi_rd_aclk;
    logic   i_axi_rd_aresetn;
    logic   i_wr_valid;
    id_t    i_wr_id;
    data_t  i_wr_data;
    logic   o_wr_ready;
    logic   o_rd_valid;
    id_t    o_rd_id;
    data_t  o_rd_data;
    logic   i_rd_ready;

    // scoreboard, one queue per ID
    data_t  exp_q [NUM_LANES][$];
    id_t    out_ids [$];
    integer seed;
    int     err_cnt;
    int     tests_run;
    int     tests_failed;
    int     chk_fails;

    // last beat seen stalled on the output
    bit     hold_seen;
    id_t    hold_id;
    data_t  hold_data;

    rd_data_cdc_top DUT (
        .i_axi_wr_aclk    (i_axi_wr_aclk),
        .i_axi_wr_aresetn (i_axi_wr_aresetn),
        .i_axi_rd_aclk    (i_axi_rd_aclk),
        .i_axi_rd_aresetn (i_axi_rd_aresetn),
        .i_wr_valid       (i_wr_valid),
        .i_wr_id          (i_wr_id),
        .i_wr_data        (i_wr_data),
        .o_wr_ready       (o_wr_ready),
        .o_rd_valid       (o_rd_valid),
        .o_rd_id          (o_rd_id),
        .o_rd_data        (o_rd_data),
        .i_rd_ready       (i_rd_ready)
    );

    always #4 i_axi_rd_aclk = ~i_axi_rd_aclk;
    always #5.5 i_axi_wr_aclk = ~i_axi_wr_aclk;

    ////////////////////
    // compare tasks

    task automatic check_data(input string name, input data_t act, input data_t exp);
        if (act !== exp) begin
            $display("ERROR %s: got 0x%08h, expected 0x%08h", name, act, exp);
            err_cnt++;
        end
    endtask

    task automatic check_id(input string name, input id_t act, input id_t exp);
        if (act !== exp) begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, act, exp);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, act, exp);
            err_cnt++;
        end
    endtask

    task automatic check_count(input string name, input int act, input int exp);
        if (act != exp) begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, act, exp);
            err_cnt++;
        end
    endtask

    ////////////////////
    // output monitor

    always @(posedge i_axi_rd_aclk) begin
        if (!i_axi_rd_aresetn) begin
            hold_seen = 1'b0;
        end else begin
            // a stalled beat must not change
            if (hold_seen) begin
                check_flag("o_rd_valid", o_rd_valid, 1'b1);
                check_id("o_rd_id", o_rd_id, hold_id);
                check_data("o_rd_data", o_rd_data, hold_data);
            end
            if (o_rd_valid && i_rd_ready) begin
                if (exp_q[o_rd_id].size() == 0) begin
                    $display("ERROR beat on ID %0d came out with none expected", o_rd_id);
                    err_cnt++;
                end else begin
                    check_data("o_rd_data", o_rd_data, exp_q[o_rd_id].pop_front());
                end
                out_ids.push_back(o_rd_id);
            end
            hold_seen = o_rd_valid && !i_rd_ready;
            hold_id   = o_rd_id;
            hold_data = o_rd_data;
        end
    end

    ////////////////////
    // drivers and waits

    task automatic send_beat(input id_t id, input data_t data, input int max_cycles,
                             output bit accepted);
        int cycles;
        accepted = 1'b0;
        cycles   = 0;
        @(posedge i_axi_wr_aclk);
        i_wr_valid <= 1'b1;
        i_wr_id    <= id;
        i_wr_data  <= data;
        while (!accepted && cycles < max_cycles) begin
            @(posedge i_axi_wr_aclk);
            cycles++;
            if (o_wr_ready) begin
                accepted = 1'b1;
                exp_q[id].push_back(data);
            end
        end
        i_wr_valid <= 1'b0;
    endtask

    // beat that has to go through
    task automatic push_beat(input id_t id, input data_t data);
        bit ok;
        send_beat(id, data, 200, ok);
        if (!ok) begin
            $display("timeout: beat on ID %0d was never accepted", id);
            err_cnt++;
        end
    endtask

    task automatic set_rd_ready(input logic value);
        @(posedge i_axi_rd_aclk);
        i_rd_ready <= value;
    endtask

    function automatic int pending_beats();
        int total;
        total = 0;
        for (int i = 0; i < NUM_LANES; i++) begin
            total += exp_q[i].size();
        end
        return total;
    endfunction

    task automatic wait_drain(input int max_cycles);
        int cycles;
        cycles = 0;
        while ((pending_beats() != 0 || o_rd_valid) && cycles < max_cycles) begin
            @(posedge i_axi_rd_aclk);
            cycles++;
        end
        if (pending_beats() != 0 || o_rd_valid) begin
            $display("timeout: %0d beats never came out of the DUT", pending_beats());
            err_cnt++;
        end
    endtask

    task automatic finish_test(input string name, input int start_err);
        tests_run++;
        if (err_cnt == start_err) begin
            $display("%-24s passed", name);
        end else begin
            tests_failed++;
            $display("%-24s failed with %0d errors", name, err_cnt - start_err);
        end
    endtask

    ////////////////////
    // tests

    task automatic reset_state_test();
        int start_err;
        start_err = err_cnt;
        @(posedge i_axi_rd_aclk);
        check_flag("o_rd_valid", o_rd_valid, 1'b0);
        @(posedge i_axi_wr_aclk);
        check_flag("o_wr_ready", o_wr_ready, 1'b1);
        finish_test("reset state", start_err);
    endtask

    task automatic single_id_stream();
        int start_err;
        start_err = err_cnt;
        out_ids.delete();
        for (int i = 0; i < 20; i++) begin
            push_beat(id_t'(1), data_t'($random(seed)));
        end
        wait_drain(400);
        check_count("beats out", out_ids.size(), 20);
        foreach (out_ids[i]) begin
            check_id("o_rd_id", out_ids[i], id_t'(1));
        end
        finish_test("single id stream", start_err);
    endtask

    task automatic full_lane_backpressure();
        int start_err;
        int accepted_cnt;
        bit ok;
        start_err    = err_cnt;
        accepted_cnt = 0;
        ok           = 1'b1;
        set_rd_ready(1'b0);
        while (ok && accepted_cnt < LANE_DEPTH + 4) begin
            send_beat(id_t'(2), data_t'($random(seed)), 40, ok);
            if (ok) begin
                accepted_cnt++;
            end
        end
        // the lane plus the one beat parked in the output register
        check_count("accepted beats on ID 2", accepted_cnt, LANE_DEPTH + 1);
        @(posedge i_axi_wr_aclk);
        check_flag("o_wr_ready", o_wr_ready, 1'b0);
        send_beat(id_t'(3), data_t'($random(seed)), 40, ok);
        check_flag("ID 3 accepted", ok, 1'b1);
        set_rd_ready(1'b1);
        wait_drain(400);
        finish_test("full lane backpressure", start_err);
    endtask

    task automatic interleaved_ids();
        int start_err;
        start_err = err_cnt;
        for (int i = 0; i < 40; i++) begin
            push_beat(id_t'($random(seed)), data_t'($random(seed)));
        end
        wait_drain(600);
        for (int i = 0; i < NUM_LANES; i++) begin
            check_count("scoreboard queue size", exp_q[i].size(), 0);
        end
        finish_test("interleaved ids", start_err);
    endtask

    task automatic random_ready_stalls();
        int start_err;
        int cycles;
        bit stall_run;
        start_err = err_cnt;
        stall_run = 1'b1;
        cycles    = 0;
        fork
            begin
                for (int i = 0; i < 30; i++) begin
                    push_beat(id_t'($random(seed)), data_t'($random(seed)));
                end
                wait_drain(1000);
                stall_run = 1'b0;
            end
            begin
                while (stall_run && cycles < 5000) begin
                    @(posedge i_axi_rd_aclk);
                    i_rd_ready <= $random(seed);
                    cycles++;
                end
            end
        join
        set_rd_ready(1'b1);
        finish_test("random ready stalls", start_err);
    endtask

    task automatic round_robin_fairness();
        int         start_err;
        int         remaining [NUM_LANES];
        int         cycles;
        lane_mask_t seen;
        id_t        id;
        start_err = err_cnt;
        seen      = '0;
        cycles    = 0;
        out_ids.delete();
        set_rd_ready(1'b0);
        for (int k = 0; k < 3; k++) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                push_beat(id_t'(i), data_t'($random(seed)));
                remaining[i] = k + 1;
            end
        end
        // first beat parked in the output register before the drain starts
        while (!o_rd_valid && cycles < 40) begin
            @(posedge i_axi_rd_aclk);
            cycles++;
        end
        if (!o_rd_valid) begin
            $display("timeout: no beat reached the output while ready was low");
            err_cnt++;
        end
        set_rd_ready(1'b1);
        wait_drain(400);
        foreach (out_ids[n]) begin
            id = out_ids[n];
            if (seen[id]) begin
                for (int j = 0; j < NUM_LANES; j++) begin
                    if (j != id && remaining[j] > 0 && !seen[j]) begin
                        $display("ERROR ID %0d served twice before ID %0d", id, j);
                        err_cnt++;
                    end
                end
                seen = '0;
            end
            seen[id] = 1'b1;
            remaining[id]--;
        end
        finish_test("round robin fairness", start_err);
    endtask

    ////////////////////
    // main sequence

    initial begin
        seed             = 32'h85;
        err_cnt          = 0;
        tests_run        = 0;
        tests_failed     = 0;
        i_axi_wr_aclk    = 1'b0;
        i_axi_rd_aclk    = 1'b0;
        i_axi_wr_aresetn = 1'b0;
        i_axi_rd_aresetn = 1'b0;
        i_wr_valid       = 1'b0;
        i_wr_id          = '0;
        i_wr_data        = '0;
        i_rd_ready       = 1'b1;
        repeat (8) @(posedge i_axi_rd_aclk);
        i_axi_wr_aresetn <= 1'b1;
        i_axi_rd_aresetn <= 1'b1;

        reset_state_test();
        single_id_stream();
        full_lane_backpressure();
        interleaved_ids();
        random_ready_stalls();
        round_robin_fairness();

        chk_fails = DUT.gen_lane[0].u_lane.u_chk.fail_cnt
                  + DUT.gen_lane[1].u_lane.u_chk.fail_cnt
                  + DUT.gen_lane[2].u_lane.u_chk.fail_cnt
                  + DUT.gen_lane[3].u_lane.u_chk.fail_cnt;
        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, err_cnt, chk_fails);
        if (err_cnt == 0 && tests_failed == 0 && chk_fails == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule : tb_rd_data_cdc

// File: verilog.f
common/rd_cdc_pkg.sv
fifo/johnson_ptr.sv
fifo/ptr_cross.sv
fifo/fifo_async_lane.sv
source/beat_steer.sv
source/lane_drain_rr.sv
source/rd_data_cdc_top.sv
test/rd_data_cdc_chk.sv
test/tb_rd_data_cdc.sv
